// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := memSubsystemTb
FILELIST := memSubsystem.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/memCtrlProperties.sv ====
`timescale 1ns/1ps

module memCtrlProperties (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic fetchPop,
    input logic dataPop,
    input logic fetchDone,
    input logic dcDone,
    input logic ioPush,
    input logic ioFull,
    input logic ramWe,
    input logic inStore
);
    // read by the testbench for its closing count
    int failCount = 0;

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dcDone)) else begin
        failCount++;
        $error("fetchDone and dcDone high in the same cycle");
    end

    // frozen controller neither pops nor finishes
    frozenQuiet: assert property (@(posedge clk) disable iff (rst)
        !rdy |-> !(fetchPop || dataPop || fetchDone || dcDone)) else begin
        failCount++;
        $error("pop or done while rdy is low");
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        ioFull |-> !ioPush) else begin
        failCount++;
        $error("ioPush while the IO buffer is full");
    end

    writeOnlyInStore: assert property (@(posedge clk) disable iff (rst)
        ramWe |-> inStore) else begin
        failCount++;
        $error("ramWe high outside the store state");
    end

endmodule

bind memCtrl memCtrlProperties u_props (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .fetchPop  (fetchPop),
    .dataPop   (dataPop),
    .fetchDone (fetchDone),
    .dcDone    (dcDone),
    .ioPush    (ioPush),
    .ioFull    (ioFull),
    .ramWe     (ramWe),
    .inStore   (state == StStore)
);

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;
    import lsuPkg::*;

    localparam int NumReqs         = 300;
    localparam int MaxCyclesPerReq = 12;
    localparam int TimeoutCycles   = NumReqs * MaxCyclesPerReq + 400;
    // 64 bytes of RAM seen through several address aliases
    localparam addrT RamMask = 32'h0001_F03F;

    logic clk;
    logic rst;
    logic rdy;
    logic fetchEn;
    addrT fetchAddr;
    logic fetchBusy;
    logic fetchDone;
    wordT fetchInst;
    logic dcEn;
    logic dcStore;
    lenT  dcLen;
    addrT dcAddr;
    wordT dcWData;
    logic dcBusy;
    logic dcDone;
    wordT dcRData;
    logic ioValid;
    byteT ioByte;
    logic ioTake;

    byteT ramModel [RamBytes];
    byteT expIo [$];
    int   mismatches  = 0;
    int   otherErrors = 0;
    int   cycles      = 0;

    memSubsystem u_dut (.*);

    always #20 clk = ~clk;

    task automatic printCounts();
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors, u_dut.u_ctrl.u_props.failCount);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            otherErrors++;
            $display("timeout after %0d cycles with requests still outstanding", cycles);
            printCounts();
            $display("Something failed");
            $finish;
        end
    end

    // random freezes and random draining of the IO buffer
    always @(posedge clk) begin
        #2;
        if (!rst) begin
            rdy    = ($urandom % 8) != 0;
            ioTake = $urandom % 2;
        end
    end

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkByte(input string name, input byteT expected, input byteT actual);
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            mismatches++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // a byte leaves the IO buffer at the next edge
    always @(negedge clk) begin
        if (!rst && ioValid && ioTake) begin
            if (expIo.size() == 0) begin
                otherErrors++;
                $display("ERROR: IO byte %h came out although none was expected", ioByte);
            end else begin
                checkByte("ioStore", expIo.pop_front(), ioByte);
            end
        end
    end

    function automatic wordT modelLoad(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        if (addr < IoBase) begin
            for (int k = 0; k < len; k++) begin
                w[8*k +: 8] = ramModel[(addr + k) & (RamBytes - 1)];
            end
        end
        return w;
    endfunction

    task automatic modelStore(input addrT addr, input lenT len, input wordT wData);
        for (int k = 0; k < len; k++) begin
            if (addr >= IoBase) begin
                expIo.push_back(wData[8*k +: 8]);
            end else begin
                ramModel[(addr + k) & (RamBytes - 1)] = wData[8*k +: 8];
            end
        end
    endtask

    function automatic lenT randLen();
        case ($urandom % 3)
            0: return LenByte;
            1: return LenHalf;
            default: return LenWord;
        endcase
    endfunction

    // data request first in the model, since the controller serves it first
    task automatic doRequest(input string name, input logic withData, input logic store,
                             input lenT len, input addrT addr, input wordT wData,
                             input logic withFetch, input addrT fAddr);
        wordT expData;
        wordT expInst;
        bit   gotData;
        bit   gotFetch;
        expData = modelLoad(addr, len);
        if (withData && store) begin
            modelStore(addr, len, wData);
        end
        expInst = modelLoad(fAddr, LenWord);
        @(posedge clk);
        #2;
        {dcEn, dcStore, dcLen, dcAddr, dcWData} = {withData, store, len, addr, wData};
        fetchEn   = withFetch;
        fetchAddr = fAddr;
        @(posedge clk);
        #2;
        dcEn     = 1'b0;
        fetchEn  = 1'b0;
        gotData  = !withData;
        gotFetch = !withFetch;
        while (!(gotData && gotFetch)) begin
            @(negedge clk);
            // one request at a time never fills a queue
            checkFlag({name, "FetchBusy"}, 1'b0, fetchBusy);
            checkFlag({name, "DcBusy"}, 1'b0, dcBusy);
            if (dcDone && withData) begin
                if (!store) begin
                    checkWord(name, expData, dcRData);
                end
                gotData = 1'b1;
            end
            if (fetchDone && withFetch) begin
                if (!gotData) begin
                    otherErrors++;
                    $display("ERROR %s: fetch finished before the data request", name);
                end
                checkWord({name, "Fetch"}, expInst, fetchInst);
                gotFetch = 1'b1;
            end
        end
    endtask

    initial begin
        int   kind;
        lenT  len;
        wordT wData;
        addrT ramAddr;
        addrT ioAddr;
        addrT fAddr;
        int   assertFails;
        void'($urandom(32'h2bd5));
        {clk, rst, rdy, ioTake} = 4'b0110;
        {fetchEn, fetchAddr, dcEn, dcStore, dcAddr, dcWData} = '0;
        dcLen = LenByte;
        for (int i = 0; i < RamBytes; i++) begin
            ramModel[i] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        // queues empty and outputs quiet right after reset
        @(negedge clk);
        checkFlag("resetFetchBusy", 1'b0, fetchBusy);
        checkFlag("resetDcBusy", 1'b0, dcBusy);
        checkFlag("resetFetchDone", 1'b0, fetchDone);
        checkFlag("resetDcDone", 1'b0, dcDone);
        checkFlag("resetIoValid", 1'b0, ioValid);
        for (int i = 0; i < NumReqs; i++) begin
            kind    = $urandom % 8;
            len     = randLen();
            wData   = $urandom;
            ramAddr = $urandom & RamMask;
            ioAddr  = IoBase + ($urandom & 32'hFF);
            fAddr   = $urandom & RamMask;
            case (kind)
                0, 1: doRequest("ramStore", 1, 1, len, ramAddr, wData, 0, '0);
                2, 3: doRequest("ramLoad", 1, 0, len, ramAddr, wData, 0, '0);
                4: doRequest("fetch", 0, 0, len, ramAddr, wData, 1, fAddr);
                5: doRequest("ioStore", 1, 1, len, ioAddr, wData, 0, '0);
                6: doRequest("ioLoad", 1, 0, len, ioAddr, wData, 0, '0);
                default: doRequest("mixed", 1, $urandom % 2, len, ramAddr, wData, 1, fAddr);
            endcase
        end
        // drain what is left in the IO buffer
        while (expIo.size() != 0 || ioValid) begin
            @(negedge clk);
        end
        assertFails = u_dut.u_ctrl.u_props.failCount;
        printCounts();
        if (mismatches + otherErrors + assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== memSubsystem.f ====
verilog/memPkg.sv
verilog/lsuPkg.sv
verilog/reqQueue.sv
verilog/byteRam.sv
verilog/memCtrl.sv
verilog/memSubsystem.sv
dv/memCtrlProperties.sv
dv/memSubsystemTb.sv

// ==== verilog/byteRam.sv ====
`timescale 1ns/1ps

module byteRam (
    input  logic                           clk,
    input  logic [memPkg::RamAddrBits-1:0] addr,
    input  logic                           we,
    input  memPkg::byteT                   wData,
    output memPkg::byteT                   rData
);
    import memPkg::*;

    byteT mem [RamBytes];

    // contents start cleared
    initial begin
        for (int i = 0; i < RamBytes; i++) begin
            mem[i] = '0;
        end
    end

    // read before write, a colliding read sees the old byte
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wData;
        end
        rData <= mem[addr];
    end

endmodule

// ==== verilog/lsuPkg.sv ====
package lsuPkg;

    // access length in bytes, only 1, 2 and 4 are legal
    typedef logic [2:0] lenT;

    localparam lenT LenByte = 3'd1;
    localparam lenT LenHalf = 3'd2;
    localparam lenT LenWord = 3'd4;

    // one data cache request as it waits in the queue
    typedef struct packed {
        logic         store;
        lenT          len;
        memPkg::addrT addr;
        memPkg::wordT wData;
    } dataReqT;

    // queue depths
    localparam int FetchDepth = 2;
    localparam int DataDepth  = 2;
    localparam int IoDepth    = 4;

endpackage

// ==== verilog/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           fetchNonEmpty,
    input  memPkg::addrT                   fetchHead,
    output logic                           fetchPop,
    input  logic                           dataNonEmpty,
    input  lsuPkg::dataReqT                dataHead,
    output logic                           dataPop,
    output logic [memPkg::RamAddrBits-1:0] ramAddr,
    output logic                           ramWe,
    output memPkg::byteT                   ramWData,
    input  memPkg::byteT                   ramRData,
    output logic                           ioPush,
    output memPkg::byteT                   ioByte,
    input  logic                           ioFull,
    output logic                           fetchDone,
    output memPkg::wordT                   fetchInst,
    output logic                           dcDone,
    output memPkg::wordT                   dcRData
);
    import memPkg::*;
    import lsuPkg::*;

    typedef enum logic [2:0] {
        StIdle,
        StFetch,
        StLoad,
        StStore,
        StIoStore
    } stateT;

    stateT state;
    lenT   stage;
    lenT   len;
    logic  ioWin;
    addrT  baseAddr;
    wordT  storeData;
    wordT  asmWord;

    lenT   issueIdx;
    addrT  byteAddr;
    wordT  fullWord;
    wordT  loadWord;
    logic  lastByte;
    logic  dataToIo;
    logic  reading;

    // data side first, fetch only when no data request waits
    always_comb begin
        dataPop  = 1'b0;
        fetchPop = 1'b0;
        if (rdy && state == StIdle) begin
            if (dataNonEmpty) begin
                dataPop = 1'b1;
            end else if (fetchNonEmpty) begin
                fetchPop = 1'b1;
            end
        end
    end

    assign dataToIo = (dataHead.addr >= IoBase);
    assign reading  = (state == StFetch) || (state == StLoad);
    assign lastByte = (stage == len - 3'd1);

    // a frozen or final cycle re-reads the previous byte, so ramRData keeps
    // the byte the assembly is still waiting for
    always_comb begin
        if (stage == len || (!rdy && stage != '0)) begin
            issueIdx = stage - 3'd1;
        end else begin
            issueIdx = stage;
        end
    end

    assign byteAddr = baseAddr + AddrWidth'(issueIdx);
    assign ramAddr  = byteAddr[RamAddrBits-1:0];

    // store bytes leave low byte first
    assign ramWe    = rdy && (state == StStore);
    assign ramWData = byteT'(storeData);
    assign ioPush   = rdy && (state == StIoStore) && !ioFull;
    assign ioByte   = byteT'(storeData);

    // newest byte enters at the top, so after L bytes the word sits in the upper lanes
    assign fullWord = {ramRData, asmWord[WordWidth-1:ByteWidth]};

    always_comb begin
        case (len)
            LenByte: loadWord = wordT'(fullWord[31:24]);
            LenHalf: loadWord = wordT'(fullWord[31:16]);
            default: loadWord = fullWord;
        endcase
    end

    assign fetchDone = rdy && (state == StFetch) && (stage == LenWord);
    assign fetchInst = fullWord;

    assign dcDone = rdy && (((state == StLoad) && (stage == len))
                          || ((state == StStore) && lastByte)
                          || (ioPush && lastByte));
    assign dcRData = ioWin ? '0 : loadWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StIdle;
            stage <= '0;
            len   <= '0;
            ioWin <= 1'b0;
        end else if (rdy) begin
            case (state)
                StIdle: begin
                    stage <= '0;
                    if (dataPop) begin
                        len   <= dataHead.len;
                        ioWin <= 1'b0;
                        if (!dataHead.store) begin
                            state <= StLoad;
                            // IO window load skips the RAM and finishes next cycle
                            if (dataToIo) begin
                                ioWin <= 1'b1;
                                stage <= dataHead.len;
                            end
                        end else if (dataToIo) begin
                            state <= StIoStore;
                        end else begin
                            state <= StStore;
                        end
                    end else if (fetchPop) begin
                        len   <= LenWord;
                        ioWin <= 1'b0;
                        state <= StFetch;
                    end
                end
                StFetch, StLoad: begin
                    if (stage == len) begin
                        state <= StIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                StStore: begin
                    if (lastByte) begin
                        state <= StIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                StIoStore: begin
                    // waits in place while the IO buffer is full
                    if (ioPush && lastByte) begin
                        state <= StIdle;
                        stage <= '0;
                    end else if (ioPush) begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= StIdle;
                    stage <= '0;
                end
            endcase
        end
    end

    // request payload and byte assembly
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (dataPop) begin
                baseAddr  <= dataHead.addr;
                storeData <= dataHead.wData;
                asmWord   <= '0;
            end else if (fetchPop) begin
                baseAddr <= fetchHead;
                asmWord  <= '0;
            end else if (reading && stage != '0 && stage != len) begin
                asmWord <= fullWord;
            end
            if (ramWe || ioPush) begin
                storeData <= storeData >> ByteWidth;
            end
        end
    end

endmodule

// ==== verilog/memPkg.sv ====
package memPkg;

    // bus widths
    localparam int AddrWidth = 32;
    localparam int ByteWidth = 8;
    localparam int WordWidth = 32;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [ByteWidth-1:0] byteT;
    typedef logic [WordWidth-1:0] wordT;

    // 4 KiB of RAM, higher address bits wrap onto the array
    localparam int RamAddrBits = 12;
    localparam int RamBytes    = 1 << RamAddrBits;

    // stores from here up go to the output byte buffer
    localparam addrT IoBase = 32'h0003_0000;

endpackage

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,

    input  logic          fetchEn,
    input  memPkg::addrT  fetchAddr,
    output logic          fetchBusy,
    output logic          fetchDone,
    output memPkg::wordT  fetchInst,

    input  logic          dcEn,
    input  logic          dcStore,
    input  lsuPkg::lenT   dcLen,
    input  memPkg::addrT  dcAddr,
    input  memPkg::wordT  dcWData,
    output logic          dcBusy,
    output logic          dcDone,
    output memPkg::wordT  dcRData,

    output logic          ioValid,
    output memPkg::byteT  ioByte,
    input  logic          ioTake
);
    import memPkg::*;
    import lsuPkg::*;

    // fetch queue to controller
    addrT    fetchHead;
    logic    fetchNonEmpty;
    logic    fetchPop;

    // data queue to controller
    dataReqT dcReq;
    dataReqT dataHead;
    logic    dataNonEmpty;
    logic    dataPop;

    // RAM port
    logic [RamAddrBits-1:0] ramAddr;
    logic    ramWe;
    byteT    ramWData;
    byteT    ramRData;

    // controller to IO buffer
    logic    ioPush;
    byteT    ctrlIoByte;
    logic    ioFull;

    assign dcReq = '{store: dcStore, len: dcLen, addr: dcAddr, wData: dcWData};

    reqQueue #(
        .itemT (addrT),
        .Depth (FetchDepth)
    ) u_fetchQueue (
        .clk      (clk),
        .rst      (rst),
        .push     (fetchEn),
        .pushItem (fetchAddr),
        .pop      (fetchPop),
        .head     (fetchHead),
        .nonEmpty (fetchNonEmpty),
        .full     (fetchBusy)
    );

    reqQueue #(
        .itemT (dataReqT),
        .Depth (DataDepth)
    ) u_dataQueue (
        .clk      (clk),
        .rst      (rst),
        .push     (dcEn),
        .pushItem (dcReq),
        .pop      (dataPop),
        .head     (dataHead),
        .nonEmpty (dataNonEmpty),
        .full     (dcBusy)
    );

    // output byte buffer, drained from outside
    reqQueue #(
        .itemT (byteT),
        .Depth (IoDepth)
    ) u_ioQueue (
        .clk      (clk),
        .rst      (rst),
        .push     (ioPush),
        .pushItem (ctrlIoByte),
        .pop      (ioTake),
        .head     (ioByte),
        .nonEmpty (ioValid),
        .full     (ioFull)
    );

    memCtrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .fetchNonEmpty (fetchNonEmpty),
        .fetchHead     (fetchHead),
        .fetchPop      (fetchPop),
        .dataNonEmpty  (dataNonEmpty),
        .dataHead      (dataHead),
        .dataPop       (dataPop),
        .ramAddr       (ramAddr),
        .ramWe         (ramWe),
        .ramWData      (ramWData),
        .ramRData      (ramRData),
        .ioPush        (ioPush),
        .ioByte        (ctrlIoByte),
        .ioFull        (ioFull),
        .fetchDone     (fetchDone),
        .fetchInst     (fetchInst),
        .dcDone        (dcDone),
        .dcRData       (dcRData)
    );

    byteRam u_ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wData (ramWData),
        .rData (ramRData)
    );

endmodule

// ==== verilog/reqQueue.sv ====
`timescale 1ns/1ps

// Depth must be at least 2
module reqQueue #(
    parameter type itemT = logic [7:0],
    parameter int  Depth = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  itemT pushItem,
    input  logic pop,
    output itemT head,
    output logic nonEmpty,
    output logic full
);
    itemT                       slots [Depth];
    logic [$clog2(Depth)-1:0]   rdPtr;
    logic [$clog2(Depth)-1:0]   wrPtr;
    logic [$clog2(Depth+1)-1:0] count;
    logic                       doPush;
    logic                       doPop;

    assign nonEmpty = (count != '0);
    assign full     = (count == Depth);
    assign head     = slots[rdPtr];

    // a full queue still takes a push when the head leaves in the same cycle
    assign doPop  = pop && nonEmpty;
    assign doPush = push && (!full || doPop);

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= pushItem;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == Depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == Depth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
